// File: design/aesEncrypt_consts.svh
// AES-128 encryption engine constants.
// Widths of the state, its columns and bytes, the round count, and the
// reduction byte for doubling in GF(2^8).

`ifndef AES_ENCRYPT_CONSTS_SVH
`define AES_ENCRYPT_CONSTS_SVH

`define AES_BLOCK_BITS 128
`define AES_WORD_BITS 32
`define AES_BYTE_BITS 8

// Full rounds after the initial key addition.
`define AES_ROUNDS 10

`define AES_REDUCE 8'h1b // x^8 folded back as x^4 + x^3 + x + 1.

`endif

// File: design/aesPkg.sv
// AES-128 encryption engine types.
// State, column and byte types follow the byte order of the standard,
// and the round core phase is kept here for the whole design.

`include "aesEncrypt_consts.svh"

package aesPkg;

	// One byte of the state.
	typedef logic [`AES_BYTE_BITS-1:0] byteT;

	// One state column or one key word.
	typedef logic [`AES_WORD_BITS-1:0] wordT;

	// Byte 0 sits in the top eight bits and column 0 in the top word.
	typedef logic [`AES_BLOCK_BITS-1:0] blockT;

	typedef logic [$clog2(`AES_ROUNDS + 1)-1:0] roundT; // Holds 0 to AES_ROUNDS.

	// Phases of the round core.
	// Idle waits for a block, round runs the full rounds and final
	// holds the last round until the output stage takes it.
	typedef enum logic [1:0]
	{
		phaseIdle,
		phaseRound,
		phaseFinal
	} corePhaseT;

endpackage

// File: design/aesSbox.sv
// AES forward S-box.
// Substitutes one byte through the standard table.

`timescale 1ns/1ps

module aesSbox (
	input  logic [7:0] in,
	output logic [7:0] out
);

	// Entry 0 is the leftmost byte, one row per high nibble.
	localparam logic [0:255][7:0] sboxTable = {
		128'h637c777b_f26b6fc5_3001672b_fed7ab76,
		128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
		128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
		128'h04c723c3_1896059a_071280e2_eb27b275,
		128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
		128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
		128'hd0efaafb_434d3385_45f9027f_503c9fa8,
		128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
		128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
		128'h60814fdc_222a9088_46eeb814_de5e0bdb,
		128'he0323a0a_4906245c_c2d3ac62_9195e479,
		128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
		128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
		128'h703eb566_4803f60e_613557b9_86c11d9e,
		128'he1f89811_69d98e94_9b1e87e9_ce5528df,
		128'h8ca1890d_bfe64268_41992d0f_b054bb16
	};

	assign out = sboxTable[in];

endmodule

// File: design/aesInputStage.sv
// AES input stage.
// One-entry buffer for plaintext and key. The initial round-key addition
// is applied as the block is taken in, so the core starts at round 1.

`timescale 1ns/1ps

module aesInputStage (
	input  logic          clk,
	input  logic          arstN,
	input  logic          inValid,
	output logic          inReady,
	input  aesPkg::blockT inText,
	input  aesPkg::blockT inKey,
	output logic          ldValid,
	input  logic          ldReady,
	output aesPkg::blockT ldState,
	output aesPkg::blockT ldKey
);

	import aesPkg::*;

	logic full;

	assign ldValid = full;
	assign inReady = !full || ldReady; // A draining buffer can refill on the same edge.

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			full <= 1'b0;
		else if (inValid && inReady)
			full <= 1'b1;
		else if (ldReady)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (inValid && inReady)
		begin
			ldState <= inText ^ inKey; // Round 0 key addition.
			ldKey   <= inKey;
		end
	end

	// While the core is busy the waiting block must not move.
	holdWhileStalled: assert property (@(posedge clk) disable iff (!arstN)
		ldValid && !ldReady |=> ldValid && $stable(ldState) && $stable(ldKey))
		else $error("Input stage block changed while stalled.");

endmodule

// File: design/aesKeySchedule.sv
// AES-128 on-the-fly key schedule.
// Holds the previous round key and its round constant. The key for the
// round in progress is derived combinationally and latched on each step.

`timescale 1ns/1ps
`include "aesEncrypt_consts.svh"

module aesKeySchedule (
	input  logic          clk,
	input  logic          arstN,
	input  logic          keyLoad,
	input  logic          keyStep,
	input  aesPkg::blockT ldKey,
	output aesPkg::blockT roundKey
);

	import aesPkg::*;

	localparam int byteW = `AES_BYTE_BITS;
	localparam int wordW = `AES_WORD_BITS;
	localparam int msb = `AES_BLOCK_BITS - 1;
	localparam byteT rconInit = 8'h01;

	blockT keyReg;
	byteT  rcon;
	wordT  w0, w1, w2, w3;
	wordT  rotWord;
	wordT  subWord;
	wordT  n0, n1, n2, n3;

	assign w0 = keyReg[msb -: wordW];
	assign w1 = keyReg[msb - wordW -: wordW];
	assign w2 = keyReg[msb - 2*wordW -: wordW];
	assign w3 = keyReg[msb - 3*wordW -: wordW];

	assign rotWord = {w3[wordW-byteW-1:0], w3[wordW-1 -: byteW]};

	for (genvar i = 0; i < wordW / byteW; i++)
	begin : gSubWord
		aesSbox sboxInst (
			.in (rotWord[wordW-1 - byteW*i -: byteW]),
			.out(subWord[wordW-1 - byteW*i -: byteW])
		);
	end

	// Each word chains off the one before it.
	assign n0 = w0 ^ subWord ^ {rcon, {(wordW - byteW){1'b0}}};
	assign n1 = w1 ^ n0;
	assign n2 = w2 ^ n1;
	assign n3 = w3 ^ n2;

	assign roundKey = {n0, n1, n2, n3};

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			rcon <= rconInit;
		else if (keyLoad)
			rcon <= rconInit;
		else if (keyStep)
			rcon <= {rcon[byteW-2:0], 1'b0} ^ (rcon[byteW-1] ? `AES_REDUCE : 8'h00);
	end

	always_ff @(posedge clk)
	begin
		if (keyLoad)
			keyReg <= ldKey;
		else if (keyStep)
			keyReg <= roundKey; // The key just used becomes the base for the next.
	end

endmodule

// File: design/aesRoundCore.sv
// AES-128 round core.
// Takes a whitened block while idle, then runs one round per clock with
// the key schedule stepping alongside. The final round skips MixColumns
// and is held on resValid until the output stage takes it.

`timescale 1ns/1ps
`include "aesEncrypt_consts.svh"

module aesRoundCore (
	input  logic          clk,
	input  logic          arstN,
	input  logic          ldValid,
	output logic          ldReady,
	input  aesPkg::blockT ldState,
	input  aesPkg::blockT ldKey,
	output logic          keyLoad,
	output logic          keyStep,
	output aesPkg::blockT roundKey,
	output logic          resValid,
	input  logic          resReady,
	output aesPkg::blockT resText
);

	import aesPkg::*;

	localparam int byteW = `AES_BYTE_BITS;
	localparam int wordW = `AES_WORD_BITS;
	localparam int msb = `AES_BLOCK_BITS - 1;
	localparam int numRows = wordW / byteW;
	localparam int numCols = `AES_BLOCK_BITS / wordW;

	corePhaseT phase;
	roundT     roundCnt;
	blockT     state;
	blockT     subState;
	blockT     shifted;
	blockT     mixed;

	function automatic byteT xtime(input byteT b);
		return {b[6:0], 1'b0} ^ (b[7] ? `AES_REDUCE : 8'h00);
	endfunction

	// Multiplies one column by the fixed MixColumns polynomial.
	function automatic wordT mixColumn(input wordT col);
		byteT a0, a1, a2, a3;
		byteT t;
		a0 = col[31:24];
		a1 = col[23:16];
		a2 = col[15:8];
		a3 = col[7:0];
		t = a0 ^ a1 ^ a2 ^ a3;
		return {a0 ^ t ^ xtime(a0 ^ a1), a1 ^ t ^ xtime(a1 ^ a2),
			a2 ^ t ^ xtime(a2 ^ a3), a3 ^ t ^ xtime(a3 ^ a0)};
	endfunction

	for (genvar i = 0; i < numRows * numCols; i++)
	begin : gSubBytes
		aesSbox sboxInst (
			.in (state[msb - byteW*i -: byteW]),
			.out(subState[msb - byteW*i -: byteW])
		);
	end

	for (genvar c = 0; c < numCols; c++)
	begin : gColumn
		for (genvar r = 0; r < numRows; r++)
		begin : gRow
			// Row r rotates left by r columns.
			assign shifted[msb - wordW*c - byteW*r -: byteW] =
				subState[msb - wordW*((c + r) % numCols) - byteW*r -: byteW];
		end
		assign mixed[msb - wordW*c -: wordW] = mixColumn(shifted[msb - wordW*c -: wordW]);
	end

	aesKeySchedule keySchedule (
		.clk     (clk),
		.arstN   (arstN),
		.keyLoad (keyLoad),
		.keyStep (keyStep),
		.ldKey   (ldKey),
		.roundKey(roundKey)
	);

	assign ldReady  = (phase == phaseIdle);
	assign keyLoad  = ldValid && ldReady;
	assign keyStep  = (phase == phaseRound);
	assign resValid = (phase == phaseFinal);
	assign resText  = shifted ^ roundKey; // Last round has no MixColumns.

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			phase    <= phaseIdle;
			roundCnt <= '0;
		end
		else
		begin
			case (phase)
				phaseIdle:
					if (keyLoad)
					begin
						phase    <= phaseRound;
						roundCnt <= roundT'(1);
					end
				phaseRound:
				begin
					roundCnt <= roundT'(roundCnt + 1'b1);
					if (roundCnt == roundT'(`AES_ROUNDS - 1))
						phase <= phaseFinal;
				end
				phaseFinal:
					if (resReady)
					begin
						phase    <= phaseIdle;
						roundCnt <= '0;
					end
				default:
					phase <= phaseIdle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (keyLoad)
			state <= ldState;
		else if (keyStep)
			state <= mixed ^ roundKey;
	end

	roundInRange: assert property (@(posedge clk) disable iff (!arstN)
		roundCnt <= roundT'(`AES_ROUNDS))
		else $error("Round counter past the last round.");

	// An accepted block keeps the core busy for every full round.
	busyAfterLoad: assert property (@(posedge clk) disable iff (!arstN)
		keyLoad |=> (!ldReady && !resValid) [*(`AES_ROUNDS - 1)] ##1 resValid)
		else $error("Core ready again before the final round.");

endmodule

// File: design/aesOutputStage.sv
// AES output stage.
// One-entry ciphertext register between the round core and the consumer.

`timescale 1ns/1ps

module aesOutputStage (
	input  logic          clk,
	input  logic          arstN,
	input  logic          resValid,
	output logic          resReady,
	input  aesPkg::blockT resText,
	output logic          outValid,
	input  logic          outReady,
	output aesPkg::blockT outText
);

	import aesPkg::*;

	logic full;

	assign outValid = full;
	assign resReady = !full || outReady;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			full <= 1'b0;
		else if (resValid && resReady)
			full <= 1'b1;
		else if (outReady)
			full <= 1'b0;
	end

	always_ff @(posedge clk)
	begin
		if (resValid && resReady)
			outText <= resText;
	end

	// The consumer sees one steady ciphertext until it takes it.
	holdUntilRead: assert property (@(posedge clk) disable iff (!arstN)
		outValid && !outReady |=> outValid && $stable(outText))
		else $error("Ciphertext changed before it was read.");

endmodule

// File: design/aesEncrypt.sv
// AES-128 streaming encryption engine.
// Input stage with key whitening, a one-round-per-clock core with its own
// key schedule, and an output holding register, all on valid/ready.

`timescale 1ns/1ps

module aesEncrypt (
	input  logic          clk,
	input  logic          arstN,
	input  logic          inValid,
	output logic          inReady,
	input  aesPkg::blockT inText,
	input  aesPkg::blockT inKey,
	output logic          outValid,
	input  logic          outReady,
	output aesPkg::blockT outText
);

	import aesPkg::*;

	logic  ldValid;
	logic  ldReady;
	blockT ldState;
	blockT ldKey;
	logic  resValid;
	logic  resReady;
	blockT resText;

	aesInputStage inputStage (
		.clk    (clk),
		.arstN  (arstN),
		.inValid(inValid),
		.inReady(inReady),
		.inText (inText),
		.inKey  (inKey),
		.ldValid(ldValid),
		.ldReady(ldReady),
		.ldState(ldState),
		.ldKey  (ldKey)
	);

	// The key schedule handshake stays inside the core.
	aesRoundCore roundCore (
		.clk     (clk),
		.arstN   (arstN),
		.ldValid (ldValid),
		.ldReady (ldReady),
		.ldState (ldState),
		.ldKey   (ldKey),
		.keyLoad (),
		.keyStep (),
		.roundKey(),
		.resValid(resValid),
		.resReady(resReady),
		.resText (resText)
	);

	aesOutputStage outputStage (
		.clk     (clk),
		.arstN   (arstN),
		.resValid(resValid),
		.resReady(resReady),
		.resText (resText),
		.outValid(outValid),
		.outReady(outReady),
		.outText (outText)
	);

endmodule

// File: sim/aesEncryptVectors.svh
// AES-128 known-answer vectors.
// Published key, plaintext and ciphertext triples for the encryption testbench.
// Columns below are key, plaintext and expected ciphertext, one entry per index.

`ifndef AES_ENCRYPT_VECTORS_SVH
`define AES_ENCRYPT_VECTORS_SVH

localparam int numVectors = 4;

localparam blockT vecKey [numVectors] = '{
	128'h2b7e151628aed2a6abf7158809cf4f3c,
	128'h000102030405060708090a0b0c0d0e0f,
	128'h00000000000000000000000000000000,
	128'h00000000000000000000000000000000
};

localparam blockT vecPlain [numVectors] = '{
	128'h3243f6a8885a308d313198a2e0370734,
	128'h00112233445566778899aabbccddeeff,
	128'h00000000000000000000000000000000,
	128'hf34481ec3cc627bacd5dc3fb08f273e6
};

localparam blockT vecCipher [numVectors] = '{
	128'h3925841d02dc09fbdc118597196a0b32,
	128'h69c4e0d86a7b0430d8cdb78070b4c55a,
	128'h66e94bd4ef8a2c3b884cfa59ca342b2e,
	128'h0336763e966d92595a567cc9ce537f5e
};

// Alternating keys, so every block needs a fresh key schedule.
localparam int keySwitchLen = 6;
localparam int keySwitchOrder [keySwitchLen] = '{0, 2, 1, 3, 1, 0};

`endif

// File: sim/aesEncryptTb.sv
// AES-128 encryption engine testbench.
// Sends known-answer blocks singly, as a stream, under random back-pressure
// and with alternating keys, and checks every ciphertext in order.

`timescale 1ns/1ps

module aesEncryptTb;

	import aesPkg::*;

	`include "aesEncryptVectors.svh"

	localparam int waitLimit = 2000;
	localparam int latencyCycles = 12; // outValid is seen in the twelfth cycle after acceptance.

	logic  clk;
	logic  arstN;
	logic  inValid;
	logic  inReady;
	blockT inText;
	blockT inKey;
	logic  outValid;
	logic  outReady;
	blockT outText;

	blockT expQ [$];
	int    acceptedCnt = 0;
	int    deliveredCnt = 0;
	logic  randomStall = 1'b0;
	logic  sawInReadyLow = 1'b0;
	logic  holdPending = 1'b0;
	blockT heldText;

	aesEncrypt aesEncrypt_inst (
		.clk     (clk),
		.arstN   (arstN),
		.inValid (inValid),
		.inReady (inReady),
		.inText  (inText),
		.inKey   (inKey),
		.outValid(outValid),
		.outReady(outReady),
		.outText (outText)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	task automatic failRun();
		$display("TB FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic reportTimeout(input string what);
		$display("Timed out while waiting for %s.", what);
		failRun();
	endtask

	// Offers one vector and returns 2 ns after the edge that accepted it.
	task automatic offerBlock(input int idx);
		int waitCnt;
		waitCnt = 0;
		inValid = 1'b1;
		inText  = vecPlain[idx];
		inKey   = vecKey[idx];
		@(negedge clk);
		while (!inReady)
		begin
			if (waitCnt >= waitLimit)
				reportTimeout("the engine to accept a block");
			waitCnt++;
			@(negedge clk);
		end
		expQ.push_back(vecCipher[idx]);
		acceptedCnt++;
		@(posedge clk);
		#2;
	endtask

	task automatic measureLatency();
		int latency;
		latency = 1;
		@(negedge clk);
		while (!outValid)
		begin
			if (latency >= waitLimit)
				reportTimeout("outValid after a single block");
			latency++;
			@(negedge clk);
		end
		latencyCheck: assert (latency == latencyCycles)
		else
		begin
			$display("[ERROR] outValid latency: got 'h%h, expected 'h%h", latency, latencyCycles);
			failRun();
		end
	endtask

	task automatic waitDrained();
		int waitCnt;
		waitCnt = 0;
		while (expQ.size() != 0)
		begin
			if (waitCnt >= waitLimit)
				reportTimeout("all outstanding ciphertexts to come out");
			waitCnt++;
			@(negedge clk);
		end
		@(posedge clk);
		#2;
	endtask

	// Back-pressure source. Ready is rare so the whole pipeline fills.
	always @(posedge clk)
	begin
		#2;
		if (randomStall)
			outReady = ($urandom_range(15, 0) == 0);
		else
			outReady = 1'b1;
	end

	// Outputs are sampled mid-cycle, where DUT and testbench values are settled.
	always @(negedge clk)
	begin
		if (arstN)
		begin
			if (!inReady)
				sawInReadyLow = 1'b1;
			if (holdPending)
			begin
				stallValid: assert (outValid)
				else
				begin
					$display("[ERROR] outValid: got 'h%h, expected 'h1 while stalled", outValid);
					failRun();
				end
				stallText: assert (outText == heldText)
				else
				begin
					$display("[ERROR] outText: got 'h%h, expected 'h%h while stalled",
						outText, heldText);
					failRun();
				end
			end
			holdPending = outValid && !outReady;
			heldText = outText;
			if (outValid && outReady)
			begin
				queueNotEmpty: assert (expQ.size() > 0)
				else
				begin
					$display("A ciphertext came out with no block outstanding.");
					failRun();
				end
				cipherMatch: assert (outText == expQ[0])
				else
				begin
					$display("[ERROR] outText: got 'h%h, expected 'h%h", outText, expQ[0]);
					failRun();
				end
				void'(expQ.pop_front());
				deliveredCnt++;
			end
		end
	end

	initial
	begin
		void'($urandom(32'hdaf8));
		arstN    = 1'b0;
		inValid  = 1'b0;
		inText   = '0;
		inKey    = '0;
		outReady = 1'b1;
		repeat (8) @(posedge clk);
		#2 arstN = 1'b1;

		@(negedge clk);
		resetOutValid: assert (!outValid)
		else
		begin
			$display("[ERROR] outValid: got 'h%h, expected 'h0 after reset", outValid);
			failRun();
		end
		resetInReady: assert (inReady)
		else
		begin
			$display("[ERROR] inReady: got 'h%h, expected 'h1 after reset", inReady);
			failRun();
		end
		@(posedge clk);
		#2;

		for (int v = 0; v < numVectors; v++)
		begin
			offerBlock(v);
			inValid = 1'b0;
			measureLatency();
			waitDrained();
		end

		for (int n = 0; n < 24; n++)
			offerBlock(int'($urandom_range(numVectors - 1, 0)));
		inValid = 1'b0;
		waitDrained();

		sawInReadyLow = 1'b0;
		randomStall = 1'b1;
		for (int n = 0; n < 16; n++)
			offerBlock(int'($urandom_range(numVectors - 1, 0)));
		inValid = 1'b0;
		randomStall = 1'b0;
		waitDrained();
		inReadyDropped: assert (sawInReadyLow)
		else
		begin
			$display("inReady never dropped while the output was stalled.");
			failRun();
		end

		for (int n = 0; n < keySwitchLen; n++)
			offerBlock(keySwitchOrder[n]);
		inValid = 1'b0;
		waitDrained();

		// Once the last ciphertext is taken nothing else may be on offer.
		@(negedge clk);
		if (!outValid && acceptedCnt == deliveredCnt)
		begin
			$display("TB PASSED");
			$finish;
		end
		else
		begin
			$display("Accepted %0d blocks, delivered %0d, and outValid is 'h%h after the last.",
				acceptedCnt, deliveredCnt, outValid);
			failRun();
		end
	end

endmodule

// File: aesEncrypt.f
+incdir+design
+incdir+sim
design/aesPkg.sv
design/aesSbox.sv
design/aesInputStage.sv
design/aesKeySchedule.sv
design/aesRoundCore.sv
design/aesOutputStage.sv
design/aesEncrypt.sv
sim/aesEncryptTb.sv

// File: Makefile
# Verilator build and run for the AES-128 encryption engine.

VERILATOR ?= verilator
TOP       ?= aesEncryptTb
FILELIST  ?= aesEncrypt.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TB PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
